// ==== design/sig_pkg.sv ====
// Signal host shared constants
// FIR tap count and coefficients, LFSR seed and taps, mixer mode codes
`default_nettype none

package sig_pkg;

    // FIR
    localparam int num_taps = 8;
    localparam logic [15:0] coeff_base = 16'h1234; // Tap k uses coeff_base + k

    // Pattern generator, reference word repeated three times
    localparam logic [191:0] pattern_seed = {
        64'h1234_5678_9ABC_DEF0,
        64'h1234_5678_9ABC_DEF0,
        64'h1234_5678_9ABC_DEF0
    };

    // Feedback bit positions
    localparam int fb_tap_hi  = 191;
    localparam int fb_tap_mid = 159;
    localparam int fb_tap_lo  = 127;

    // Mixer modes, numbered as on proc_mode
    localparam logic [1:0] mode_lowpass  = 2'd0;
    localparam logic [1:0] mode_highpass = 2'd1;
    localparam logic [1:0] mode_bandpass = 2'd2;
    localparam logic [1:0] mode_notch    = 2'd3;

endpackage

`default_nettype wire

// ==== design/mix_if.sv ====
// Mixer bus
// Five operand bytes and a mode in, one 16-bit result out
`timescale 1ns/1ps
`default_nettype none

interface mix_if;

    logic [7:0]  a;
    logic [7:0]  b;
    logic [7:0]  c;
    logic [7:0]  d;
    logic [7:0]  e;
    logic [1:0]  mode;
    logic [15:0] y;    // Combinational from operands and mode

    // Operand source
    modport pattern (output a, b, c, d, e);

    // Sequencer side
    modport ctrl (output mode, input y);

    // Arithmetic block
    modport mixer (input a, b, c, d, e, mode, output y);

endinterface

`default_nettype wire

// ==== design/pattern_lfsr.sv ====
// Pattern LFSR
// 192-bit shift register stepped once per accepted sample, feeds the mixer operands
`timescale 1ns/1ps
`default_nettype none

module pattern_lfsr (
    input  logic clk,
    input  logic rst,
    input  logic step,
    mix_if.pattern mix
);

    import sig_pkg::*;

    logic [191:0] state;
    logic         fb;

    // Three-tap feedback
    assign fb = state[fb_tap_hi] ^ state[fb_tap_mid] ^ state[fb_tap_lo];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= pattern_seed;
        end else if (step) begin
            state <= {state[190:0], fb}; // Shift left, feedback into bit 0
        end
    end

    // Operand bytes from the low middle of the state
    assign mix.a = state[55:48];
    assign mix.b = state[47:40];
    assign mix.c = state[39:32];
    assign mix.d = state[31:24];
    assign mix.e = state[23:16];

endmodule

`default_nettype wire

// ==== design/mode_mixer.sv ====
// Mode mixer
// Four-mode byte arithmetic, 16-bit wrapping result, purely combinational
`timescale 1ns/1ps
`default_nettype none

module mode_mixer (
    mix_if.mixer mix
);

    import sig_pkg::*;

    logic [15:0] wa;
    logic [15:0] wb;
    logic [15:0] wc;
    logic [15:0] wd;
    logic [15:0] we;
    logic [15:0] byte_sum;

    // Zero-extended operands so every result wraps at 16 bits
    assign wa = {8'h00, mix.a};
    assign wb = {8'h00, mix.b};
    assign wc = {8'h00, mix.c};
    assign wd = {8'h00, mix.d};
    assign we = {8'h00, mix.e};

    assign byte_sum = wa + wb + wc + wd + we;

    always_comb begin
        mix.y = 16'h0000;
        case (mix.mode)
            mode_lowpass: begin
                mix.y = wa * wb + wc;
            end
            mode_highpass: begin
                mix.y = (wc * wd) ^ {mix.e, mix.a};
            end
            mode_bandpass: begin
                mix.y = byte_sum << 4; // Upper bits drop out
            end
            mode_notch: begin
                mix.y = {mix.d, mix.e} - {mix.a, mix.b};
            end
            default: begin
                mix.y = 16'h0000;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/fir_mac.sv ====
// FIR multiply-accumulate
// 8-entry delay line with fixed coefficients, one tap product added per mac_step cycle
`timescale 1ns/1ps
`default_nettype none

module fir_mac (
    input  logic        clk,
    input  logic        rst,
    input  logic        load,
    input  logic        mac_step,
    input  logic [15:0] sample,
    output logic [31:0] acc
);

    import sig_pkg::*;

    logic [15:0] delay_line [0:num_taps-1];
    logic [2:0]  tap_idx;
    logic [15:0] coeff;
    logic [31:0] prod;

    // Coefficient ramp from the base value
    assign coeff = coeff_base + {13'd0, tap_idx};

    // Full 16x16 product
    assign prod = {16'h0000, delay_line[tap_idx]} * {16'h0000, coeff};

    // Newest sample at position 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_taps; i++) begin
                delay_line[i] <= 16'h0000;
            end
        end else if (load) begin
            delay_line[0] <= sample;
            for (int i = 1; i < num_taps; i++) begin
                delay_line[i] <= delay_line[i-1];
            end
        end
    end

    // Tap walk
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tap_idx <= 3'd0;
        end else if (load) begin
            tap_idx <= 3'd0;
        end else if (mac_step) begin
            tap_idx <= tap_idx + 3'd1; // Wraps to 0 after tap 7
        end
    end

    // Accumulator, wraps at 32 bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= 32'h0000_0000;
        end else if (load) begin
            acc <= 32'h0000_0000;
        end else if (mac_step) begin
            acc <= acc + prod;
        end
    end

endmodule

`default_nettype wire

// ==== design/host_seq.sv ====
// Host sequencer
// Idle / accumulate / output control, drives the MAC and LFSR and registers the result
`timescale 1ns/1ps
`default_nettype none

module host_seq (
    input  logic        clk,
    input  logic        rst,
    input  logic        enable,
    input  logic [1:0]  proc_mode,
    input  logic [31:0] acc,
    output logic        load,
    output logic        mac_step,
    output logic        step,
    mix_if.ctrl         mix,
    output logic [15:0] signal_out,
    output logic        processing_done
);

    import sig_pkg::*;

    logic       acc_phase;  // Eight MAC cycles
    logic       out_phase;  // Result cycle
    logic       idle;
    logic [2:0] mac_cnt;

    assign idle = !acc_phase && !out_phase;

    // Accept only while idle
    assign load     = enable && idle;
    assign step     = load;
    assign mac_step = acc_phase;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc_phase       <= 1'b0;
            out_phase       <= 1'b0;
            mac_cnt         <= 3'd0;
            mix.mode        <= mode_lowpass;
            signal_out      <= 16'h0000;
            processing_done <= 1'b0;
        end else begin
            processing_done <= 1'b0; // Single-cycle pulse
            if (load) begin
                acc_phase <= 1'b1;
                mac_cnt   <= 3'd0;
                mix.mode  <= proc_mode; // Held for the whole operation
            end else if (acc_phase) begin
                mac_cnt <= mac_cnt + 3'd1;
                if (mac_cnt == 3'(num_taps - 1)) begin
                    acc_phase <= 1'b0;
                    out_phase <= 1'b1;
                end
            end else if (out_phase) begin
                // Accumulator is final one cycle after the last MAC step
                signal_out      <= acc[15:0] ^ mix.y;
                processing_done <= 1'b1;
                out_phase       <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/signal_host.sv ====
// Signal processing host top
// FIR filter result mixed with LFSR-driven arithmetic, one result per accepted sample
`timescale 1ns/1ps
`default_nettype none

module signal_host (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] signal_in,
    input  logic [1:0]  proc_mode,
    input  logic        enable,
    output logic [15:0] signal_out,
    output logic        processing_done
);

    logic        load;
    logic        mac_step;
    logic        step;
    logic [31:0] acc;

    mix_if mix_i ();

    pattern_lfsr lfsr_i (
        .clk  (clk),
        .rst  (rst),
        .step (step),
        .mix  (mix_i.pattern)
    );

    mode_mixer mixer_i (
        .mix (mix_i.mixer)
    );

    fir_mac fir_i (
        .clk      (clk),
        .rst      (rst),
        .load     (load),
        .mac_step (mac_step),
        .sample   (signal_in),
        .acc      (acc)
    );

    host_seq seq_i (
        .clk             (clk),
        .rst             (rst),
        .enable          (enable),
        .proc_mode       (proc_mode),
        .acc             (acc),
        .load            (load),
        .mac_step        (mac_step),
        .step            (step),
        .mix             (mix_i.ctrl),
        .signal_out      (signal_out),
        .processing_done (processing_done)
    );

endmodule

`default_nettype wire

// ==== sim/tb_signal_host.sv ====
// Signal host testbench
// Random samples through the DUT, results checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_signal_host;

    import sig_pkg::*;

    logic        clk = 1'b0;
    logic        rst;
    logic [15:0] signal_in;
    logic [1:0]  proc_mode;
    logic        enable;
    logic [15:0] signal_out;
    logic        processing_done;

    int          cyc = 0;          // Edge count, settles to k after edge k
    logic [31:0] rng_state = 32'hfab92d48;

    // Reference state
    logic [15:0]  model_line [0:num_taps-1];
    logic [191:0] model_lfsr;

    // Expected results in acceptance order
    logic [15:0] exp_val_q [$];
    int          exp_edge_q [$];

    signal_host dut_i (
        .clk             (clk),
        .rst             (rst),
        .signal_in       (signal_in),
        .proc_mode       (proc_mode),
        .enable          (enable),
        .signal_out      (signal_out),
        .processing_done (processing_done)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [191:0] pattern_step(input logic [191:0] s);
        return {s[190:0], s[fb_tap_hi] ^ s[fb_tap_mid] ^ s[fb_tap_lo]};
    endfunction

    // Mixer table on the operand bytes of one pattern state
    function automatic logic [15:0] mix_expected(input logic [191:0] s, input logic [1:0] md);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        logic [15:0] d;
        logic [15:0] e;
        logic [15:0] r;
        a = {8'h00, s[55:48]};
        b = {8'h00, s[47:40]};
        c = {8'h00, s[39:32]};
        d = {8'h00, s[31:24]};
        e = {8'h00, s[23:16]};
        case (md)
            2'd0: r = a * b + c;
            2'd1: r = (c * d) ^ {s[23:16], s[55:48]};
            2'd2: r = (a + b + c + d + e) << 4;
            default: r = {s[31:24], s[23:16]} - {s[55:48], s[47:40]};
        endcase
        return r;
    endfunction

    function automatic void restart_model();
        for (int k = 0; k < num_taps; k++) begin
            model_line[k] = 16'h0000;
        end
        model_lfsr = pattern_seed;
    endfunction

    // One accepted sample: shift, step the pattern, full FIR sum
    function automatic logic [15:0] predict_result(input logic [15:0] smp, input logic [1:0] md);
        logic [31:0] sum;
        sum = 32'h0000_0000;
        for (int k = num_taps - 1; k > 0; k--) begin
            model_line[k] = model_line[k-1];
        end
        model_line[0] = smp;
        model_lfsr = pattern_step(model_lfsr);
        for (int k = 0; k < num_taps; k++) begin
            sum = sum + 32'(model_line[k]) * 32'(coeff_base + 16'(k));
        end
        return sum[15:0] ^ mix_expected(model_lfsr, md);
    endfunction

    // Accept edge is one after the drive edge; then 9 busy edges
    task automatic drive_sample(input logic [15:0] smp, input logic [1:0] md, input logic hold);
        @(posedge clk);
        signal_in <= smp;
        proc_mode <= md;
        enable    <= 1'b1;
        exp_val_q.push_back(predict_result(smp, md));
        exp_edge_q.push_back(cyc + 2);
        repeat (9) begin
            @(posedge clk);
            if (hold) begin
                rng_state = next_random(rng_state);
                signal_in <= rng_state[15:0]; // Junk while busy
                proc_mode <= rng_state[17:16];
                enable    <= 1'b1;
            end else begin
                enable <= 1'b0;
            end
        end
    endtask

    // Stimulus
    initial begin
        int          drain;
        logic [1:0]  md;
        rst       <= 1'b1;
        enable    <= 1'b0;
        signal_in <= 16'h0000;
        proc_mode <= 2'd0;
        restart_model();
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Quiet after reset
        repeat (20) begin
            @(negedge clk);
            assert (signal_out == 16'h0000) else
                report_failure($sformatf("ERROR at %0d ns: signal_out expected %h got %h",
                               $time, 16'h0000, signal_out));
            assert (!processing_done) else
                report_failure("processing_done rose after reset with enable low");
        end

        for (int i = 0; i < 200; i++) begin
            rng_state = next_random(rng_state);
            md = (i < 4) ? 2'(i) : rng_state[17:16]; // All four modes up front
            drive_sample(rng_state[15:0], md, 1'b0);
            repeat (rng_state[21:20]) @(posedge clk);
        end

        // Enable held high, accepts land 10 cycles apart
        for (int i = 0; i < 20; i++) begin
            rng_state = next_random(rng_state);
            drive_sample(rng_state[15:0], rng_state[17:16], 1'b1);
        end
        @(posedge clk);
        enable <= 1'b0;
        repeat (12) @(posedge clk);

        // Reset lands on the edge where done would rise
        @(posedge clk);
        signal_in <= 16'h5a5a;
        proc_mode <= 2'd1;
        enable    <= 1'b1;
        repeat (10) begin
            @(posedge clk);
            enable <= 1'b0;
        end
        rst <= 1'b1;
        restart_model();
        @(negedge clk);
        assert (signal_out == 16'h0000) else
            report_failure($sformatf("ERROR at %0d ns: signal_out expected %h got %h",
                           $time, 16'h0000, signal_out));
        assert (!processing_done) else
            report_failure("processing_done not cleared by reset");
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < 10; i++) begin
            rng_state = next_random(rng_state);
            drive_sample(rng_state[15:0], rng_state[17:16], 1'b0);
        end

        drain = 0;
        while (exp_val_q.size() != 0 && drain < 40) begin
            @(negedge clk);
            drain = drain + 1;
        end
        if (exp_val_q.size() != 0) begin
            report_failure("results still outstanding at the end of the run");
        end else begin
            repeat (3) @(negedge clk); // Last pulse must fall
            $display("All checks passed");
            $finish;
        end
    end

    // Comparison, outputs sampled on the falling edge
    initial begin
        int          waited;
        logic        got;
        logic [15:0] exp_val;
        int          exp_edge;
        forever begin
            waited = 0;
            while (exp_val_q.size() == 0) begin
                @(negedge clk);
                waited = waited + 1;
                assert (!processing_done) else
                    report_failure("processing_done rose with no sample accepted");
                if (waited > 1000) report_failure("no sample accepted for 1000 cycles");
            end
            waited = 0;
            got = 1'b0;
            while (!got && waited < 20) begin
                @(negedge clk);
                waited = waited + 1;
                if (processing_done) begin
                    exp_val  = exp_val_q.pop_front();
                    exp_edge = exp_edge_q.pop_front();
                    got      = 1'b1;
                end
            end
            if (!got) report_failure("processing_done missing 20 cycles after a sample");
            assert (cyc - exp_edge == 9) else
                report_failure($sformatf("ERROR at %0d ns: processing_done latency expected %0d got %0d",
                               $time, 9, cyc - exp_edge));
            assert (signal_out == exp_val) else
                report_failure($sformatf("ERROR at %0d ns: signal_out expected %h got %h",
                               $time, exp_val, signal_out));
            @(negedge clk);
            assert (!processing_done) else
                report_failure("processing_done stayed high for more than one cycle");
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
design/sig_pkg.sv
design/mix_if.sv
design/pattern_lfsr.sv
design/mode_mixer.sv
design/fir_mac.sv
design/host_seq.sv
design/signal_host.sv
sim/tb_signal_host.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the signal host testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timescale 1ns/1ps --top-module tb_signal_host \
    -f list.f -o tb_signal_host &&
./obj_dir/tb_signal_host | tee /dev/stderr | grep -q "All checks passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }
